// ==== flist.f ====
hdl/cpu_mem_pkg.sv
hdl/boot_loader.sv
hdl/instr_mem.sv
hdl/data_mem.sv
hdl/host_writer.sv
hdl/cpu_mem_top.sv
tb/tb_clock.sv
tb/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, fails unless the pass message is printed"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/tb_top.sv ====
////////////////////////////////////////////////////////////
// testbench for the memory and host side; models the host,
// boots the DUT, then exercises core and accelerator ports
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module tb_top import cpu_mem_pkg::*; ();

    localparam logic [31:0]       seed        = 32'h335;
    localparam int                seg_total   = dm_seg_count + im_seg_count;
    localparam int                boot_cycles = seg_total * (line_words + 6);
    localparam int                test_cycles = im_seg_count * line_words + dm_seg_count + 60;
    localparam int                timeout_ns  = (16 + boot_cycles + test_cycles) * 8 * 4;
    localparam logic [addr_w-1:0] dm_bytes    = addr_w'(dm_depth * 4);

    logic clk, rst_n, ready, rd_valid, tx_done;
    logic core_wrt_en, core_rd_en, accel_wrt_en, accel_rd_en;
    logic core_stall, accel_wrt_done, accel_rd_valid;
    logic [data_w-1:0] host_wrt_data, host_rd_data, core_wrt_data, accel_wrt_data;
    logic [data_w-1:0] core_instr, core_rd_data;
    logic [addr_w-1:0] core_fetch_addr, core_addr, accel_addr;
    logic [host_addr_w-1:0] host_addr, prev_addr, exp_req, exp_haddr;
    logic [line_w-1:0] accel_rd_data;
    host_op_t host_op, prev_op, exp_op;

    // expectations from the stimulus and their one-cycle delay in the compare process
    logic instr_chk = 0, rd_chk = 0, line_chk = 0, wdone_chk = 0;
    logic instr_pend = 0, rd_pend = 0, line_pend = 0, wdone_pend = 0;
    logic [data_w-1:0] instr_exp, rd_exp, instr_pend_val, rd_pend_val, exp_hdata;
    logic [line_w-1:0] line_exp, line_pend_val;
    logic boot_phase = 0, run_phase = 0, exp_stall;
    logic [31:0] rng_state = seed;
    int req_cnt = 0;

    tb_clock u_clk (.clk(clk));

    cpu_mem_top dut (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // word the host hands out for a byte address
    function automatic logic [data_w-1:0] expected_word(input logic [addr_w-1:0] addr);
        return xorshift32(xorshift32(seed ^ {addr, ~addr}));
    endfunction

    function automatic logic [line_w-1:0] expected_line(input logic [addr_w-1:0] addr);
        logic [line_w-1:0] line;
        logic [addr_w-1:0] base;
        base = addr & ~addr_w'(line_words * 4 - 1);  // line aligned
        for (int i = 0; i < line_words; i++)
            line[i*data_w +: data_w] = expected_word(base + addr_w'(4 * i));
        return line;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [line_w-1:0] got,
                         input logic [line_w-1:0] exp);
        if (got !== exp)
            abort_run($sformatf("error at %0t ns: %s is %h, expected %h",
                                $time, name, got, exp));
    endtask

    initial begin
        #(timeout_ns);
        abort_run("watchdog expired before the tests finished");
    end

    ////////////////////////////////////////////////////////////
    // compare process sampling at the rising edge
    ////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        check("accel_wrt_done", line_w'(accel_wrt_done), line_w'(wdone_pend));
        check("accel_rd_valid", line_w'(accel_rd_valid), line_w'(line_pend));
        if (line_pend) check("accel_rd_data", accel_rd_data, line_pend_val);
        if (instr_pend) check("core_instr", line_w'(core_instr), line_w'(instr_pend_val));
        if (rd_pend) check("core_rd_data", line_w'(core_rd_data), line_w'(rd_pend_val));
        if (!boot_phase && !run_phase) begin  // reset and before ready
            check("host_op", line_w'(host_op), line_w'(op_idle));
            check("core_stall", line_w'(core_stall), line_w'(1'b1));
        end
        if (boot_phase) begin
            check("core_stall", line_w'(core_stall), line_w'(1'b1));
            if (host_op != op_read) begin
                check("host_op", line_w'(host_op), line_w'(op_idle));
            end else if (prev_op != op_read || host_addr != prev_addr) begin
                if (req_cnt >= seg_total)
                    abort_run("boot loader requested more segments than the tables hold");
                if (req_cnt < dm_seg_count) begin
                    exp_req = host_addr_w'(dm_seg_base[req_cnt]);
                end else begin
                    exp_req = host_addr_w'(im_seg_base[req_cnt - dm_seg_count]);
                    exp_req[im_host_flag_bit] = 1'b1;
                end
                check("host_addr", line_w'(host_addr), line_w'(exp_req));
                req_cnt++;
            end
        end
        if (run_phase) begin
            check("host_op", line_w'(host_op), line_w'(exp_op));
            check("core_stall", line_w'(core_stall), line_w'(exp_stall));
            if (exp_op == op_write) begin
                check("host_addr", line_w'(host_addr), line_w'(exp_haddr));
                check("host_rd_data", line_w'(host_rd_data), line_w'(exp_hdata));
            end
        end
        prev_op        = host_op;
        prev_addr      = host_addr;
        instr_pend     = instr_chk;
        instr_pend_val = instr_exp;
        rd_pend        = rd_chk;
        rd_pend_val    = rd_exp;
        line_pend      = line_chk;
        line_pend_val  = line_exp;
        wdone_pend     = wdone_chk;
    end

    ////////////////////////////////////////////////////////////
    // host model and core stimulus on the falling edge
    ////////////////////////////////////////////////////////////
    task automatic serve_segment();
        logic [addr_w-1:0] base;
        logic [31:0] r;
        while (host_op != op_read)
            @(negedge clk);
        base = host_addr[addr_w-1:0];
        r = next_rand();
        repeat (r[1:0]) @(negedge clk);  // host holds off rd_valid
        rd_valid      = 1'b1;
        host_wrt_data = expected_word(base);
        @(negedge clk);
        rd_valid = 1'b0;
        for (int i = 1; i < line_words; i++) begin
            host_wrt_data = expected_word(base + addr_w'(4 * i));
            tx_done       = (i == line_words - 1);  // last word
            @(negedge clk);
        end
        tx_done = 1'b0;
    endtask

    task automatic core_read(input logic [addr_w-1:0] addr, input logic [data_w-1:0] value);
        core_addr  = addr;
        core_rd_en = 1'b1;
        rd_exp     = value;
        rd_chk     = 1'b1;
        @(negedge clk);
        core_rd_en = 1'b0;
        rd_chk     = 1'b0;
    endtask

    task automatic core_store(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
        core_addr     = addr;
        core_wrt_data = data;
        core_wrt_en   = 1'b1;
        @(negedge clk);
        core_wrt_en = 1'b0;
    endtask

    // store into the host window
    // old is the aliased memory word and must stay unchanged
    task automatic window_store(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
                                input logic [data_w-1:0] old);
        logic [31:0] r;
        r = next_rand();
        core_addr     = addr;
        core_wrt_data = data;
        core_wrt_en   = 1'b1;
        exp_stall     = 1'b1;  // stall in the request cycle
        @(negedge clk);
        exp_op    = op_write;
        exp_haddr = host_addr_w'(addr);
        exp_hdata = data;
        for (int i = 0; i <= int'(r[1:0]); i++) begin
            tx_done = (i == int'(r[1:0]));
            @(negedge clk);
        end
        tx_done   = 1'b0;
        exp_op    = op_idle;
        exp_stall = 1'b0;  // core sees the store done here
        @(negedge clk);
        core_wrt_en = 1'b0;
        core_read(addr % dm_bytes, old);
    endtask

    initial begin
        logic [31:0] r, kept;
        {rst_n, ready, rd_valid, tx_done} = '0;
        {core_wrt_en, core_rd_en, accel_wrt_en, accel_rd_en} = '0;
        host_wrt_data   = '0;
        core_wrt_data   = '0;
        accel_wrt_data  = '0;
        core_fetch_addr = '0;
        core_addr       = '0;
        accel_addr      = '0;
        exp_op          = op_idle;
        exp_stall       = 1'b0;
        repeat (16) @(posedge clk);  // 16 rising edges in reset
        @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);
        ready      = 1'b1;
        boot_phase = 1'b1;
        repeat (seg_total) serve_segment();
        boot_phase = 1'b0;
        run_phase  = 1'b1;

        instr_chk = 1'b1;  // fetch every loaded word
        for (int s = 0; s < im_seg_count; s++) begin
            for (int i = 0; i < line_words; i++) begin
                core_fetch_addr = im_seg_base[s] + addr_w'(4 * i);
                instr_exp       = expected_word(core_fetch_addr);
                @(negedge clk);
            end
        end
        instr_chk = 1'b0;

        accel_rd_en = 1'b1;  // one line per data segment from an unaligned start
        line_chk    = 1'b1;
        for (int s = 0; s < dm_seg_count; s++) begin
            accel_addr = dm_seg_base[s] + addr_w'(8 * s);
            line_exp   = expected_line(accel_addr);
            @(negedge clk);
        end
        accel_rd_en = 1'b0;
        line_chk    = 1'b0;

        r = next_rand();
        accel_addr     = 16'h1044;
        accel_wrt_data = r;
        accel_wrt_en   = 1'b1;
        wdone_chk      = 1'b1;
        @(negedge clk);
        accel_wrt_en = 1'b0;
        wdone_chk    = 1'b0;
        core_read(16'h1044, r);

        r = next_rand();
        core_store(16'h1108, r);
        core_read(16'h1108, r);
        kept = next_rand();
        core_store(16'h1ffc, kept);
        core_read(16'h1ffc, kept);

        window_store(16'h9104, next_rand(), expected_word(16'h1104));
        window_store(16'hfffc, next_rand(), kept);
        repeat (4) @(negedge clk);

        if (req_cnt == seg_total) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            abort_run("boot loader issued too few segment requests");
        end
    end

endmodule

// ==== tb/tb_clock.sv ====
////////////////////////////////////////////////////////////
// free-running testbench clock, 8 ns period
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // half period
    end

endmodule

// ==== hdl/cpu_mem_top.sv ====
////////////////////////////////////////////////////////////
// memory and host side of the CPU; the core and the
// accelerator attach to the loose ports here
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module cpu_mem_top import cpu_mem_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    // host link
    input  logic                   ready,
    input  logic                   rd_valid,
    input  logic                   tx_done,
    input  logic [data_w-1:0]      host_wrt_data,
    output host_op_t               host_op,
    output logic [host_addr_w-1:0] host_addr,
    output logic [data_w-1:0]      host_rd_data,
    // core
    input  logic [addr_w-1:0]      core_fetch_addr,
    input  logic [addr_w-1:0]      core_addr,
    input  logic [data_w-1:0]      core_wrt_data,
    input  logic                   core_wrt_en,
    input  logic                   core_rd_en,
    output logic [data_w-1:0]      core_instr,
    output logic [data_w-1:0]      core_rd_data,
    output logic                   core_stall,
    // accelerator
    input  logic [addr_w-1:0]      accel_addr,
    input  logic [data_w-1:0]      accel_wrt_data,
    input  logic                   accel_wrt_en,
    input  logic                   accel_rd_en,
    output logic                   accel_wrt_done,
    output logic                   accel_rd_valid,
    output logic [line_w-1:0]      accel_rd_data
);

    logic [addr_w-1:0]      load_addr;
    logic [data_w-1:0]      load_data;
    logic                   dm_load_en, im_load_en;
    logic                   boot_done;
    host_op_t               boot_op;
    logic [host_addr_w-1:0] boot_host_addr;
    logic                   dm_store_en;

    boot_loader u_boot (
        .clk(clk), .rst_n(rst_n), .ready(ready), .rd_valid(rd_valid), .tx_done(tx_done),
        .host_wrt_data(host_wrt_data), .boot_op(boot_op), .boot_host_addr(boot_host_addr),
        .load_addr(load_addr), .load_data(load_data), .dm_load_en(dm_load_en),
        .im_load_en(im_load_en), .boot_done(boot_done));

    instr_mem u_imem (
        .clk(clk), .rst_n(rst_n), .load_addr(load_addr), .load_data(load_data),
        .im_load_en(im_load_en), .core_fetch_addr(core_fetch_addr), .core_instr(core_instr));

    data_mem u_dmem (
        .clk(clk), .rst_n(rst_n), .load_addr(load_addr), .load_data(load_data),
        .dm_load_en(dm_load_en), .core_addr(core_addr), .core_wrt_data(core_wrt_data),
        .dm_store_en(dm_store_en), .core_rd_en(core_rd_en), .accel_addr(accel_addr),
        .accel_wrt_data(accel_wrt_data), .accel_wrt_en(accel_wrt_en),
        .accel_rd_en(accel_rd_en), .core_rd_data(core_rd_data),
        .accel_wrt_done(accel_wrt_done), .accel_rd_valid(accel_rd_valid),
        .accel_rd_data(accel_rd_data));

    host_writer u_hwr (
        .clk(clk), .rst_n(rst_n), .boot_done(boot_done), .boot_op(boot_op),
        .boot_host_addr(boot_host_addr), .core_addr(core_addr),
        .core_wrt_data(core_wrt_data), .core_wrt_en(core_wrt_en), .tx_done(tx_done),
        .dm_store_en(dm_store_en), .core_stall(core_stall), .host_op(host_op),
        .host_addr(host_addr), .host_rd_data(host_rd_data));

endmodule

// ==== hdl/host_writer.sv ====
////////////////////////////////////////////////////////////
// host link output side; muxes boot reads with run-phase
// host writes and owns the core stall
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module host_writer import cpu_mem_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   boot_done,
    input  host_op_t               boot_op,
    input  logic [host_addr_w-1:0] boot_host_addr,
    input  logic [addr_w-1:0]      core_addr,
    input  logic [data_w-1:0]      core_wrt_data,
    input  logic                   core_wrt_en,
    input  logic                   tx_done,
    output logic                   dm_store_en,
    output logic                   core_stall,
    output host_op_t               host_op,
    output logic [host_addr_w-1:0] host_addr,
    output logic [data_w-1:0]      host_rd_data
);

    write_state_t      wr_state;
    logic              wr_ack;  // held store was just finished, don't resend
    logic              above_window;
    logic              host_hit;
    logic [addr_w-1:0] st_addr;
    logic [data_w-1:0] st_data;

    assign above_window = (core_addr >= host_window);
    assign host_hit     = boot_done && core_wrt_en && above_window &&
                          (wr_state == wr_idle) && !wr_ack;
    assign dm_store_en  = boot_done && core_wrt_en && !above_window &&
                          (wr_state == wr_idle);
    assign core_stall   = !boot_done || host_hit || (wr_state == wr_busy);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_state <= wr_idle;
            wr_ack   <= 1'b0;
        end else begin
            wr_ack <= 1'b0;
            case (wr_state)
                wr_idle: if (host_hit) wr_state <= wr_busy;
                wr_busy: begin
                    if (tx_done) begin
                        wr_state <= wr_idle;
                        wr_ack   <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (host_hit) begin
            st_addr <= core_addr;
            st_data <= core_wrt_data;
        end
    end

    always_comb begin
        host_op      = op_idle;
        host_addr    = '0;
        host_rd_data = '0;
        if (!boot_done) begin
            host_op   = boot_op;  // boot loader owns the link
            host_addr = boot_host_addr;
        end else if (wr_state == wr_busy) begin
            host_op      = op_write;
            host_addr    = {{(host_addr_w - addr_w){1'b0}}, st_addr};
            host_rd_data = st_data;
        end
    end

    a_no_write_in_boot: assert property (@(posedge clk) disable iff (!rst_n)
        !boot_done |-> (host_op != op_write));

endmodule

// ==== hdl/data_mem.sv ====
////////////////////////////////////////////////////////////
// data store with boot, core load/store and accelerator
// ports; the accelerator reads a whole 16-word line at once
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module data_mem import cpu_mem_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [addr_w-1:0] load_addr,
    input  logic [data_w-1:0] load_data,
    input  logic              dm_load_en,
    input  logic [addr_w-1:0] core_addr,
    input  logic [data_w-1:0] core_wrt_data,
    input  logic              dm_store_en,
    input  logic              core_rd_en,
    input  logic [addr_w-1:0] accel_addr,
    input  logic [data_w-1:0] accel_wrt_data,
    input  logic              accel_wrt_en,
    input  logic              accel_rd_en,
    output logic [data_w-1:0] core_rd_data,
    output logic              accel_wrt_done,
    output logic              accel_rd_valid,
    output logic [line_w-1:0] accel_rd_data
);

    logic [data_w-1:0]              mem [dm_depth];
    logic [dm_idx_w-1:0]            core_idx;
    logic [dm_idx_w-1:0]            accel_idx;
    logic [dm_idx_w-line_sel_w-1:0] line_base;  // line number of accel_addr

    assign core_idx  = core_addr[dm_idx_w+1:2];
    assign accel_idx = accel_addr[dm_idx_w+1:2];
    assign line_base = accel_addr[dm_idx_w+1:line_sel_w+2];

    ////////////////////////////////////////////////////////////
    // write ports
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (accel_wrt_en)
            mem[accel_idx] <= accel_wrt_data;
        // boot and core writes come last so they win a collision
        if (dm_load_en)
            mem[load_addr[dm_idx_w+1:2]] <= load_data;
        else if (dm_store_en)
            mem[core_idx] <= core_wrt_data;
    end

    ////////////////////////////////////////////////////////////
    // read ports
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (core_rd_en)
            core_rd_data <= mem[core_idx];
    end

    always_ff @(posedge clk) begin
        if (accel_rd_en) begin
            for (int i = 0; i < line_words; i++) begin
                // word 0 of the line in the low bits
                accel_rd_data[i*data_w +: data_w] <= mem[{line_base, i[line_sel_w-1:0]}];
            end
        end
    end

    // one-cycle strobes back to the accelerator
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            accel_wrt_done <= 1'b0;
            accel_rd_valid <= 1'b0;
        end else begin
            accel_wrt_done <= accel_wrt_en;
            accel_rd_valid <= accel_rd_en;
        end
    end

    a_accel_one_op: assert property (@(posedge clk) disable iff (!rst_n)
        !(accel_rd_en && accel_wrt_en));

endmodule

// ==== hdl/instr_mem.sv ====
////////////////////////////////////////////////////////////
// instruction store; written by the boot loader, read by
// the core fetch port with one cycle of latency
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module instr_mem import cpu_mem_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [addr_w-1:0] load_addr,
    input  logic [data_w-1:0] load_data,
    input  logic              im_load_en,
    input  logic [addr_w-1:0] core_fetch_addr,
    output logic [data_w-1:0] core_instr
);

    logic [data_w-1:0] mem [im_depth];

    always_ff @(posedge clk) begin
        if (im_load_en)
            mem[load_addr[im_idx_w+1:2]] <= load_data;  // word index
    end

    // registered fetch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            core_instr <= '0;
        else
            core_instr <= mem[core_fetch_addr[im_idx_w+1:2]];
    end

    a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        (core_fetch_addr[1:0] == 2'b00) && (!im_load_en || load_addr[1:0] == 2'b00));

endmodule

// ==== hdl/boot_loader.sv ====
////////////////////////////////////////////////////////////
// boot sequencer; pulls every data then instruction segment
// from the host and streams the words into the memories
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module boot_loader import cpu_mem_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   ready,
    input  logic                   rd_valid,
    input  logic                   tx_done,
    input  logic [data_w-1:0]      host_wrt_data,
    output host_op_t               boot_op,
    output logic [host_addr_w-1:0] boot_host_addr,
    output logic [addr_w-1:0]      load_addr,
    output logic [data_w-1:0]      load_data,
    output logic                   dm_load_en,
    output logic                   im_load_en,
    output logic                   boot_done
);

    boot_state_t            state, next_state;
    logic [seg_cnt_w-1:0]   seg_cnt, next_seg;
    logic [addr_w-1:0]      cur_addr, next_addr;  // next word of the segment
    logic [addr_w-1:0]      seg_base;
    logic                   is_im;
    logic                   last_seg;

    assign is_im    = (state == wait_im) || (state == load_im);
    assign seg_base = is_im ? im_seg_base[seg_cnt] : dm_seg_base[seg_cnt];
    assign last_seg = is_im ? (seg_cnt == seg_cnt_w'(im_seg_count - 1))
                            : (seg_cnt == seg_cnt_w'(dm_seg_count - 1));

    assign load_data = host_wrt_data;  // host word goes straight to memory
    assign boot_done = (state == run);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= boot_idle;
            seg_cnt  <= '0;
            cur_addr <= '0;
        end else begin
            state    <= next_state;
            seg_cnt  <= next_seg;
            cur_addr <= next_addr;
        end
    end

    always_comb begin
        next_state     = state;
        next_seg       = seg_cnt;
        next_addr      = cur_addr;
        boot_op        = op_idle;
        boot_host_addr = '0;
        load_addr      = cur_addr;
        dm_load_en     = 1'b0;
        im_load_en     = 1'b0;

        // read request held for the whole segment
        if (state inside {wait_dm, load_dm, wait_im, load_im}) begin
            boot_op        = op_read;
            boot_host_addr = {{(host_addr_w - addr_w){1'b0}}, seg_base};
            if (is_im)
                boot_host_addr[im_host_flag_bit] = 1'b1;
        end

        case (state)
            boot_idle: begin
                if (ready)
                    next_state = wait_dm;
            end
            wait_dm, wait_im: begin
                load_addr = seg_base;  // word 0 lands at the base
                if (rd_valid) begin
                    dm_load_en = !is_im;
                    im_load_en = is_im;
                    next_addr  = seg_base + addr_w'(4);
                    next_state = is_im ? load_im : load_dm;
                end
            end
            load_dm, load_im: begin
                dm_load_en = !is_im;
                im_load_en = is_im;
                next_addr  = cur_addr + addr_w'(4);
                if (tx_done) begin
                    if (last_seg) begin
                        next_seg   = '0;
                        next_state = is_im ? run : wait_im;
                    end else begin
                        next_seg   = seg_cnt + seg_cnt_w'(1);
                        next_state = is_im ? wait_im : wait_dm;
                    end
                end
            end
            run:     next_state = run;
            default: next_state = boot_idle;
        endcase
    end

    // host may only open a segment once per request
    a_no_valid_in_load: assert property (@(posedge clk) disable iff (!rst_n)
        (state == load_dm || state == load_im) |-> !rd_valid);

endmodule

// ==== hdl/cpu_mem_pkg.sv ====
////////////////////////////////////////////////////////////
// shared widths, boot segment tables and state encodings
// for the memory and host side; imported by every RTL file
////////////////////////////////////////////////////////////
package cpu_mem_pkg;

    localparam int addr_w      = 16;  // core byte address
    localparam int data_w      = 32;
    localparam int host_addr_w = 64;
    localparam int line_words  = 16;  // accel line and boot segment
    localparam int im_depth    = 256;
    localparam int dm_depth    = 2048;

    // derived index widths
    localparam int im_idx_w   = $clog2(im_depth);
    localparam int dm_idx_w   = $clog2(dm_depth);
    localparam int line_sel_w = $clog2(line_words);
    localparam int line_w     = line_words * data_w;

    ////////////////////////////////////////////////////////////
    // boot segment tables
    ////////////////////////////////////////////////////////////
    localparam int dm_seg_count = 4;
    localparam int im_seg_count = 4;
    localparam int seg_cnt_w    = $clog2((dm_seg_count > im_seg_count) ?
                                         dm_seg_count : im_seg_count);

    localparam logic [addr_w-1:0] dm_seg_base [dm_seg_count] =
        '{16'h1000, 16'h1040, 16'h1100, 16'h1140};
    localparam logic [addr_w-1:0] im_seg_base [im_seg_count] =
        '{16'h0000, 16'h0040, 16'h0080, 16'h00C0};

    localparam int im_host_flag_bit = 16;  // marks an instruction segment request

    // stores at or above this go out to the host
    localparam logic [addr_w-1:0] host_window = 16'h9000;

    ////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {
        op_idle  = 2'b00,
        op_read  = 2'b01,
        op_write = 2'b11
    } host_op_t;

    typedef enum logic [2:0] {
        boot_idle, wait_dm, load_dm, wait_im, load_im, run
    } boot_state_t;

    typedef enum logic {wr_idle, wr_busy} write_state_t;

endpackage
